// ==== cache_top.f ====
rtl/cache_pkg.sv
rtl/cache_control.sv
rtl/cache_datapath.sv
rtl/cache_top.sv
tests/pmem_model.sv
tests/tb_cache_top.sv

// ==== rtl/cache_control.sv ====
`timescale 1ns/1ns

module cache_control import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input cpu_req_t req,
	input stat_t stat,
	input logic pmem_resp,
	output ctrl_t ctrl,
	output logic resp,
	output logic pmem_read,
	output logic pmem_write
);

	typedef enum logic [1:0] {
		idle,
		lookup,
		write_back,
		fill
	} state_t;

	state_t state;
	state_t next_state;
	logic cpu_active;

	assign cpu_active = req.read | req.write;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (cpu_active) begin
					next_state = lookup;
				end
			end
			lookup: begin
				if (stat.hit) begin
					next_state = idle;
				end else if (stat.victim_dirty) begin
					next_state = write_back;
				end else begin
					next_state = fill;
				end
			end
			write_back: begin
				if (pmem_resp) begin
					next_state = fill;
				end
			end
			fill: begin
				// lookup again, which now hits and answers the cpu
				if (pmem_resp) begin
					next_state = lookup;
				end
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	always_comb begin
		ctrl = '0;
		resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		case (state)
			idle: begin
			end
			lookup: begin
				if (stat.hit) begin
					resp = 1'b1;
					ctrl.lru_write = 1'b1;
					// write hit merges the word and marks the line dirty
					if (req.write) begin
						ctrl.data_write = 1'b1;
						ctrl.dirty_write = 1'b1;
						ctrl.dirty_value = 1'b1;
					end
				end
			end
			write_back: begin
				pmem_write = 1'b1;
				ctrl.wb_addr_sel = 1'b1;
				if (pmem_resp) begin
					ctrl.dirty_write = 1'b1;
					ctrl.dirty_value = 1'b0;
				end
			end
			fill: begin
				pmem_read = 1'b1;
				ctrl.fill_sel = 1'b1;
				// rline is only valid in the resp cycle
				if (pmem_resp) begin
					ctrl.tag_write = 1'b1;
					ctrl.valid_write = 1'b1;
					ctrl.data_write = 1'b1;
					ctrl.dirty_write = 1'b1;
					ctrl.dirty_value = 1'b0;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== rtl/cache_datapath.sv ====
`timescale 1ns/1ns

module cache_datapath import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input cache_addr_u addr,
	input logic [word_bits-1:0] wdata,
	input ctrl_t ctrl,
	input logic [line_bits-1:0] pmem_rline,
	output stat_t stat,
	output logic [word_bits-1:0] rdata,
	output logic [word_bits-1:0] pmem_addr,
	output logic [line_bits-1:0] pmem_wline
);

	typedef logic [words_per_line-1:0][word_bits-1:0] line_t;

	// per set, per way
	logic [tag_bits-1:0] tag_arr [num_sets][2];
	line_t data_arr [num_sets][2];
	logic [1:0] valid_arr [num_sets];
	logic [1:0] dirty_arr [num_sets];
	// points at the least recently used way of each set
	logic [num_sets-1:0] lru_arr;

	logic [set_bits-1:0] set_idx;
	logic [offset_bits-1:0] word_idx;
	logic [1:0] way_hit;
	logic hit;
	logic victim;
	logic way_sel;
	line_t sel_line;
	line_t victim_line;
	line_t merged_line;
	line_t write_line;
	cache_addr_u mem_addr;

	assign set_idx = addr.fields.set;
	assign word_idx = addr.fields.offset;
	assign victim = lru_arr[set_idx];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_arr[set_idx][w] &&
				(tag_arr[set_idx][w] == addr.fields.tag);
		end
	end

	assign hit = |way_hit;

	always_comb begin
		stat.hit = hit;
		stat.victim_dirty = valid_arr[set_idx][victim] && dirty_arr[set_idx][victim];
	end

	// a hit works on its own way, a miss on the lru victim
	assign way_sel = hit ? way_hit[1] : victim;

	assign sel_line = data_arr[set_idx][way_sel];
	assign victim_line = data_arr[set_idx][victim];

	assign rdata = sel_line[word_idx];

	always_comb begin
		merged_line = sel_line;
		merged_line[word_idx] = wdata;
	end

	assign write_line = ctrl.fill_sel ? line_t'(pmem_rline) : merged_line;

	// write-back goes to the victim's own line, fill to the cpu line
	always_comb begin
		mem_addr.fields.tag = ctrl.wb_addr_sel ? tag_arr[set_idx][victim] : addr.fields.tag;
		mem_addr.fields.set = set_idx;
		mem_addr.fields.offset = '0;
		mem_addr.fields.byte_sel = 1'b0;
	end

	assign pmem_addr = mem_addr.raw;
	assign pmem_wline = victim_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_arr[s] <= '0;
				dirty_arr[s] <= '0;
			end
			lru_arr <= '0;
		end else begin
			if (ctrl.valid_write) begin
				valid_arr[set_idx][way_sel] <= 1'b1;
			end
			if (ctrl.dirty_write) begin
				dirty_arr[set_idx][way_sel] <= ctrl.dirty_value;
			end
			// the way just used becomes most recent
			if (ctrl.lru_write) begin
				lru_arr[set_idx] <= ~way_sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.tag_write) begin
			tag_arr[set_idx][way_sel] <= addr.fields.tag;
		end
		if (ctrl.data_write) begin
			data_arr[set_idx][way_sel] <= write_line;
		end
	end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

	// address fields from high to low are tag, set, word offset and byte
	localparam int tag_bits = 9;
	localparam int set_bits = 3;
	localparam int offset_bits = 3;
	localparam int num_sets = 8;
	localparam int words_per_line = 8;
	localparam int word_bits = 16;
	localparam int line_bits = 128;

	typedef struct packed {
		logic [tag_bits-1:0] tag;
		logic [set_bits-1:0] set;
		logic [offset_bits-1:0] offset;
		logic byte_sel;
	} cache_addr_t;

	// the same 16 bits, either as a raw word or split for the lookup
	typedef union packed {
		logic [word_bits-1:0] raw;
		cache_addr_t fields;
	} cache_addr_u;

	typedef struct packed {
		logic read;
		logic write;
		cache_addr_u addr;
		logic [word_bits-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic resp;
		logic [word_bits-1:0] rdata;
	} cpu_rsp_t;

	// addr is always line aligned
	typedef struct packed {
		logic read;
		logic write;
		logic [word_bits-1:0] addr;
		logic [line_bits-1:0] wline;
	} pmem_req_t;

	typedef struct packed {
		logic resp;
		logic [line_bits-1:0] rline;
	} pmem_rsp_t;

	typedef struct packed {
		logic lru_write;
		logic valid_write;
		logic data_write;
		logic tag_write;
		logic dirty_write;
		logic dirty_value;
		logic fill_sel;
		logic wb_addr_sel;
	} ctrl_t;

	typedef struct packed {
		logic hit;
		logic victim_dirty;
	} stat_t;

endpackage

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ns

module cache_top import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	output pmem_req_t pmem_req,
	input pmem_rsp_t pmem_rsp
);

	ctrl_t ctrl;
	stat_t stat;
	logic resp;
	logic pmem_read;
	logic pmem_write;
	logic [word_bits-1:0] rdata;
	logic [word_bits-1:0] pmem_addr;
	logic [line_bits-1:0] pmem_wline;

	cache_control control_i (
		.clk(clk),
		.rst(rst),
		.req(cpu_req),
		.stat(stat),
		.pmem_resp(pmem_rsp.resp),
		.ctrl(ctrl),
		.resp(resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	cache_datapath datapath_i (
		.clk(clk),
		.rst(rst),
		.addr(cpu_req.addr),
		.wdata(cpu_req.wdata),
		.ctrl(ctrl),
		.pmem_rline(pmem_rsp.rline),
		.stat(stat),
		.rdata(rdata),
		.pmem_addr(pmem_addr),
		.pmem_wline(pmem_wline)
	);

	// control owns the handshake bits, datapath the payload
	assign cpu_rsp = '{resp: resp, rdata: rdata};

	assign pmem_req = '{
		read: pmem_read,
		write: pmem_write,
		addr: pmem_addr,
		wline: pmem_wline
	};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_cache_top -f cache_top.f \
	&& ./obj_dir/Vtb_cache_top > sim.log 2>&1 \
	|| echo "build or simulation exited with an error"

cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && exit 0 || exit 1

// ==== tests/pmem_model.sv ====
`timescale 1ns/1ns

module pmem_model import cache_pkg::*; #(
	parameter int delay = 3,
	parameter logic [15:0] seed = 16'd58
) (
	input logic clk,
	input logic rst,
	input pmem_req_t req,
	output pmem_rsp_t rsp
);

	logic [7:0] mem [65536];
	int count;

	// galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 16'hb400;
		end
		return next;
	endfunction

	// each bit taken is the lsb of the state, then the lfsr steps once
	initial begin
		logic [15:0] state;
		logic [7:0] value;
		rsp <= '0;
		state = seed;
		value = '0;
		for (int a = 0; a < 65536; a++) begin
			for (int b = 0; b < 8; b++) begin
				value = {value[6:0], state[0]};
				state = lfsr_next(state);
			end
			mem[16'(a)] = value;
		end
	end

	// byte k of a line sits at line address + k
	always @(posedge clk) begin
		logic [15:0] a;
		if (rst) begin
			count <= 0;
			rsp.resp <= 1'b0;
		end else begin
			rsp.resp <= 1'b0;
			if ((req.read || req.write) && !rsp.resp) begin
				if (count == delay) begin
					count <= 0;
					rsp.resp <= 1'b1;
					for (int k = 0; k < 16; k++) begin
						a = req.addr + 16'(k);
						if (req.read) begin
							rsp.rline[8*k +: 8] <= mem[a];
						end
						if (req.write) begin
							mem[a] = req.wline[8*k +: 8];
						end
					end
				end else begin
					count <= count + 1;
				end
			end
		end
	end

endmodule

// ==== tests/tb_cache_top.sv ====
`timescale 1ns/1ns

module tb_cache_top import cache_pkg::*; ();

	localparam int num_steps = 15;
	localparam int mem_delay = 3;
	localparam int resp_timeout = 200;
	localparam int idle_cycles = 10;

	typedef struct packed {
		logic is_write;
		logic [15:0] addr;
		logic [15:0] wdata;
		logic [3:0] fills;
		logic [3:0] wbs;
	} step_t;

	logic clk = 1'b0;
	logic rst;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	pmem_req_t pmem_req;
	pmem_rsp_t pmem_rsp;

	step_t steps [num_steps];
	logic [15:0] ref_mem [32768];
	// two-way reference of the tag state
	logic [8:0] ref_tag [8][2];
	logic ref_valid [8][2];
	logic ref_lru [8];

	int fill_count;
	int wb_count;
	logic [15:0] wb_addr;
	logic [127:0] wb_line;

	always #20 clk = ~clk;

	cache_top cache_top_i (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.pmem_req(pmem_req),
		.pmem_rsp(pmem_rsp)
	);

	pmem_model #(.delay(mem_delay), .seed(16'd58)) memory_i (
		.clk(clk),
		.rst(rst),
		.req(pmem_req),
		.rsp(pmem_rsp)
	);

	// memory traffic seen at the cache ports
	always @(posedge clk) begin
		if (rst) begin
			fill_count <= 0;
			wb_count <= 0;
		end else if (pmem_rsp.resp) begin
			if (pmem_req.read) begin
				fill_count <= fill_count + 1;
			end
			if (pmem_req.write) begin
				wb_count <= wb_count + 1;
				wb_addr <= pmem_req.addr;
				wb_line <= pmem_req.wline;
			end
		end
	end

	function automatic logic [15:0] make_addr(input logic [8:0] tag, input logic [2:0] set,
		input logic [2:0] offset);
		return {tag, set, offset, 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic wait_for_resp(output logic [15:0] rdata);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!cpu_rsp.resp) begin
			if (cycles == resp_timeout) begin
				$display("the cache gave no cpu response within %0d cycles", resp_timeout);
				$display("Test failures found");
				$fatal(1, "cpu response timeout");
			end else begin
				cycles++;
				@(negedge clk);
			end
		end
		rdata = cpu_rsp.rdata;
	endtask

	// returns the line address of the way that a miss would evict
	task automatic model_access(input logic [15:0] a, output logic [15:0] victim_addr);
		logic [8:0] tag;
		logic [2:0] set;
		logic way;
		logic found;
		tag = a[15:7];
		set = a[6:4];
		way = ref_lru[set];
		found = 1'b0;
		if (ref_valid[set][0] && ref_tag[set][0] == tag) begin
			way = 1'b0;
			found = 1'b1;
		end
		if (ref_valid[set][1] && ref_tag[set][1] == tag) begin
			way = 1'b1;
			found = 1'b1;
		end
		victim_addr = {ref_tag[set][way], set, 4'b0000};
		if (!found) begin
			ref_tag[set][way] = tag;
			ref_valid[set][way] = 1'b1;
		end
		ref_lru[set] = ~way;
	endtask

	initial begin
		logic [14:0] widx;
		step_t st;
		logic [15:0] rdata;
		logic [15:0] victim_addr;
		int fills_before;
		int wbs_before;
		rst = 1'b1;
		cpu_req = '0;
		for (int s = 0; s < 8; s++) begin
			ref_valid[s][0] = 1'b0;
			ref_valid[s][1] = 1'b0;
			ref_lru[s] = 1'b0;
		end
		// op, address, write data, fills, write-backs
		steps = '{
			'{1'b0, make_addr(9'd5, 3'd2, 3'd1), 16'h0000, 4'd1, 4'd0},
			'{1'b0, make_addr(9'd5, 3'd2, 3'd6), 16'h0000, 4'd0, 4'd0},
			'{1'b1, make_addr(9'd5, 3'd2, 3'd3), 16'hbeef, 4'd0, 4'd0},
			'{1'b0, make_addr(9'd5, 3'd2, 3'd3), 16'h0000, 4'd0, 4'd0},
			'{1'b0, make_addr(9'd9, 3'd2, 3'd0), 16'h0000, 4'd1, 4'd0},
			'{1'b0, make_addr(9'd5, 3'd2, 3'd2), 16'h0000, 4'd0, 4'd0},
			'{1'b0, make_addr(9'd9, 3'd2, 3'd7), 16'h0000, 4'd0, 4'd0},
			'{1'b0, make_addr(9'd12, 3'd2, 3'd4), 16'h0000, 4'd1, 4'd1},
			'{1'b0, make_addr(9'd5, 3'd2, 3'd3), 16'h0000, 4'd1, 4'd0},
			'{1'b1, make_addr(9'd12, 3'd2, 3'd4), 16'h1234, 4'd0, 4'd0},
			'{1'b0, make_addr(9'd9, 3'd2, 3'd7), 16'h0000, 4'd1, 4'd0},
			'{1'b0, make_addr(9'd3, 3'd2, 3'd0), 16'h0000, 4'd1, 4'd1},
			'{1'b0, make_addr(9'd12, 3'd2, 3'd4), 16'h0000, 4'd1, 4'd0},
			'{1'b1, make_addr(9'd7, 3'd5, 3'd0), 16'h0f0f, 4'd1, 4'd0},
			'{1'b0, make_addr(9'd7, 3'd5, 3'd0), 16'h0000, 4'd0, 4'd0}
		};
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int w = 0; w < 32768; w++) begin
			widx = 15'(w);
			ref_mem[widx] = {memory_i.mem[{widx, 1'b1}], memory_i.mem[{widx, 1'b0}]};
		end

		// nothing may move while no request is driven
		repeat (idle_cycles) begin
			@(negedge clk);
			check_value("idle resp", 32'd0, 32'(cpu_rsp.resp));
			check_value("idle pmem read", 32'd0, 32'(pmem_req.read));
			check_value("idle pmem write", 32'd0, 32'(pmem_req.write));
		end

		for (int i = 0; i < num_steps; i++) begin
			st = steps[i];
			fills_before = fill_count;
			wbs_before = wb_count;
			model_access(st.addr, victim_addr);
			@(posedge clk);
			cpu_req.read <= ~st.is_write;
			cpu_req.write <= st.is_write;
			cpu_req.addr.raw <= st.addr;
			cpu_req.wdata <= st.wdata;
			wait_for_resp(rdata);
			@(posedge clk);
			cpu_req.read <= 1'b0;
			cpu_req.write <= 1'b0;

			check_value($sformatf("step %0d fills", i), 32'(st.fills),
				32'(fill_count - fills_before));
			check_value($sformatf("step %0d write-backs", i), 32'(st.wbs),
				32'(wb_count - wbs_before));
			if (wb_count != wbs_before) begin
				check_value($sformatf("step %0d wb address", i), 32'(victim_addr),
					32'(wb_addr));
				for (int k = 0; k < 8; k++) begin
					check_value($sformatf("step %0d wb word %0d", i, k),
						32'(ref_mem[{wb_addr[15:4], 3'(k)}]), 32'(wb_line[16*k +: 16]));
				end
			end
			if (st.is_write) begin
				ref_mem[st.addr[15:1]] = st.wdata;
			end else begin
				check_value($sformatf("step %0d rdata", i), 32'(ref_mem[st.addr[15:1]]),
					32'(rdata));
			end
		end

		$display("All tests passed!");
		$finish;
	end

endmodule
